/* hw/mmu_ctrl_pkg.sv */
package mmu_ctrl_pkg;

    // Request kind, carried on the Wishbone address tag
    typedef enum logic [1:0] {
        op_translate = 2'd0,
        op_load      = 2'd1,
        op_inval     = 2'd2
    } op_t;

    // Control flag word held steady by the system
    localparam int mcr_w          = 3;
    localparam int mcr_virt_user  = 0; // User accesses are virtual
    localparam int mcr_virt_super = 1; // Supervisor accesses are virtual
    localparam int mcr_dual_space = 2; // User runs in its own address space

    // Protection level of a page, as stored in the entry
    typedef enum logic [1:0] {
        prot_none_user  = 2'd0, // Supervisor read only
        prot_super_only = 2'd1, // Supervisor read and write
        prot_user_read  = 2'd2, // User may only read
        prot_all        = 2'd3
    } prot_t;

endpackage

/* hw/mmu_entry_pkg.sv */
package mmu_entry_pkg;

    // Cache geometry
    localparam int num_sets = 16;
    localparam int set_w    = $clog2(num_sets);
    localparam int tag_w    = 12;
    localparam int pfn_w    = 20;
    localparam int entry_w  = 36;

    // Stored entry layout {tag, prot, we, ci, pfn}
    localparam int ent_pfn_lo  = 0;
    localparam int ent_ci      = 20;
    localparam int ent_we      = 21;
    localparam int ent_prot_lo = 22;
    localparam int ent_tag_lo  = 24;

    // Bit positions in the write data of a load or invalidate
    localparam int ld_pfn_lo  = 12;
    localparam int ld_prot_lo = 6;
    localparam int ld_we      = 5;
    localparam int ld_ci      = 4;
    localparam int ld_as      = 0;

endpackage

/* hw/mmu_decode.sv */
`timescale 1ns/1ps

module mmu_decode (
    input  logic                           bclk,
    input  logic                           reset,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  logic [31:0]                    wb_adr,
    input  logic [31:0]                    wb_dat_i,
    input  mmu_ctrl_pkg::op_t              wb_tga,
    input  logic                           user,
    input  logic                           rmw,
    input  logic [mmu_ctrl_pkg::mcr_w-1:0] mcr_flags,
    input  logic                           done,
    output logic                           req_valid,
    output mmu_ctrl_pkg::op_t              req_op,
    output logic [31:12]                   req_va,
    output logic [11:0]                    req_offset,
    output logic                           req_write,
    output logic                           req_user,
    output logic                           req_rmw,
    output logic [31:0]                    req_data,
    output logic                           virt,
    output logic                           adr_space,
    output logic [mmu_entry_pkg::num_sets-1:0] set_mask
);
    import mmu_ctrl_pkg::*;
    import mmu_entry_pkg::*;

    logic busy;
    logic accept;

    assign accept = wb_cyc & wb_stb & ~busy;

    always_ff @(posedge bclk) begin
        if (reset) begin
            req_valid <= 1'b0;
            busy      <= 1'b0;
        end else begin
            req_valid <= accept;            // One-cycle pulse into match
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge bclk) begin
        if (accept) begin
            req_op     <= wb_tga;
            req_va     <= wb_adr[31:12];
            req_offset <= wb_adr[11:0];
            req_write  <= wb_we;
            req_user   <= user;
            req_rmw    <= rmw;
            req_data   <= wb_dat_i;
            virt       <= user ? mcr_flags[mcr_virt_user] : mcr_flags[mcr_virt_super];
            // Load and invalidate name the space explicitly
            adr_space  <= (wb_tga != op_translate) ? wb_dat_i[ld_as]
                                                   : (mcr_flags[mcr_dual_space] & user);
            set_mask   <= num_sets'(1) << wb_adr[12 +: set_w];
        end
    end

    // Answer only for the request in flight, two edges after it is registered
    a_done_in_flight: assert property (@(posedge bclk) disable iff (reset)
        done |-> busy);
    a_answer_time: assert property (@(posedge bclk) disable iff (reset)
        req_valid |-> ##2 done);

endmodule

/* hw/mmu_match.sv */
`timescale 1ns/1ps

module mmu_match (
    input  logic                                 bclk,
    input  logic                                 reset,
    input  logic                                 req_valid,
    input  mmu_ctrl_pkg::op_t                    req_op,
    input  logic [31:12]                         req_va,
    input  logic                                 req_write,
    input  logic                                 req_user,
    input  logic                                 req_rmw,
    input  logic [31:0]                          req_data,
    input  logic                                 virt,
    input  logic                                 adr_space,
    input  logic [mmu_entry_pkg::num_sets-1:0]   set_mask,
    input  logic                                 commit,
    input  logic [31:0]                          update,
    output logic                                 ex_valid,
    output mmu_ctrl_pkg::op_t                    ex_op,
    output logic                                 ex_hit,
    output logic                                 ex_miss,
    output logic                                 ex_prot_error,
    output logic                                 ex_ci,
    output logic                                 ex_space,
    output logic [mmu_entry_pkg::pfn_w-1:0]      ex_pfn,
    output logic [31:12]                         ex_offset_va,
    output logic [31:0]                          update_word,
    output logic                                 entry_we
);
    import mmu_ctrl_pkg::*;
    import mmu_entry_pkg::*;

    logic [entry_w-1:0]    entry_mem [num_sets];
    logic [2*num_sets-1:0] mvalid;             // {space bits, valid bits}
    logic [entry_w-1:0]    entry;
    logic [entry_w-1:0]    new_entry;
    logic [tag_w-1:0]      ent_tag;
    prot_t                 ent_prot;
    logic                  as_sorte;
    logic                  valid_bit;
    logic                  match;
    logic                  translate;
    logic                  prot_err;
    logic                  hit;
    logic [num_sets-1:0]   val_bits;
    logic [num_sets-1:0]   as_bits;

    assign entry     = entry_mem[req_va[12 +: set_w]];
    assign ent_tag   = entry[ent_tag_lo +: tag_w];
    assign ent_prot  = prot_t'(entry[ent_prot_lo +: $bits(prot_t)]);
    assign as_sorte  = |(mvalid[2*num_sets-1:num_sets] & set_mask);
    assign valid_bit = |(mvalid[num_sets-1:0] & set_mask);
    assign match     = (req_va[31 -: tag_w] == ent_tag) & (adr_space == as_sorte) & valid_bit;
    assign translate = (req_op == op_translate);

    always_comb begin
        prot_err = 1'b0;
        if (translate & virt & match) begin
            case (ent_prot)
                prot_none_user:  prot_err = req_user | req_write | req_rmw;
                prot_super_only: prot_err = req_user;
                prot_user_read:  prot_err = req_user & (req_write | req_rmw);
                default:         prot_err = 1'b0;
            endcase
        end
    end

    // Physical accesses always pass
    assign hit = virt ? (match & (~req_write | entry[ent_we]) & ~prot_err) : 1'b1;

    always_comb begin
        val_bits = mvalid[num_sets-1:0];
        as_bits  = mvalid[2*num_sets-1:num_sets];
        if (req_op == op_load) begin
            val_bits = val_bits | set_mask;
            as_bits  = adr_space ? (as_bits | set_mask) : (as_bits & ~set_mask);
        end else if (req_op == op_inval && match) begin
            val_bits = val_bits & ~set_mask;
        end
    end

    assign entry_we  = req_valid & (req_op == op_load);
    assign new_entry = {req_va[31 -: tag_w],
                        req_data[ld_prot_lo +: $bits(prot_t)],
                        req_data[ld_we],
                        req_data[ld_ci],
                        req_data[ld_pfn_lo +: pfn_w]};

    always_ff @(posedge bclk) begin
        if (entry_we) begin
            entry_mem[req_va[12 +: set_w]] <= new_entry;
        end
    end

    always_ff @(posedge bclk) begin
        if (reset) begin
            mvalid <= '0;
        end else if (commit) begin
            mvalid <= update;                  // Written back from result
        end
    end

    always_ff @(posedge bclk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= req_valid;
        end
    end

    always_ff @(posedge bclk) begin
        ex_op         <= req_op;
        ex_hit        <= hit;
        ex_miss       <= translate & virt & ~match;
        ex_prot_error <= prot_err;
        ex_ci         <= virt & entry[ent_ci];
        ex_space      <= adr_space;
        ex_pfn        <= entry[ent_pfn_lo +: pfn_w];
        ex_offset_va  <= req_va;
        update_word   <= {as_bits, val_bits};
    end

    a_mask_onehot: assert property (@(posedge bclk) disable iff (reset)
        req_valid |-> $onehot(set_mask));

endmodule

/* hw/mmu_result.sv */
`timescale 1ns/1ps

module mmu_result (
    input  logic                            bclk,
    input  logic                            reset,
    input  logic                            ex_valid,
    input  mmu_ctrl_pkg::op_t               ex_op,
    input  logic                            ex_hit,
    input  logic                            ex_miss,
    input  logic                            ex_prot_error,
    input  logic                            ex_ci,
    input  logic                            ex_space,
    input  logic [mmu_entry_pkg::pfn_w-1:0] ex_pfn,
    input  logic [31:12]                    ex_offset_va,
    input  logic [11:0]                     req_offset,
    input  logic [31:0]                     update_word,
    input  logic                            virt_r,
    output logic                            commit,
    output logic [31:0]                     update,
    output logic [31:0]                     wb_dat_o,
    output logic                            wb_ack,
    output logic                            wb_err,
    output logic                            prot_error,
    output logic                            miss,
    output logic                            ci,
    output logic                            sel_ptb1,
    output logic                            done
);
    import mmu_ctrl_pkg::*;

    logic translate;

    assign translate = (ex_op == op_translate);

    // Valid word goes back to match on the same edge as the answer
    assign commit = ex_valid & ~translate;
    assign update = update_word;
    assign done   = wb_ack | wb_err;

    always_ff @(posedge bclk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            wb_err <= 1'b0;
        end else begin
            wb_ack <= ex_valid & (~translate | ex_hit);
            wb_err <= ex_valid & translate & ~ex_hit;
        end
    end

    always_ff @(posedge bclk) begin
        if (ex_valid) begin
            wb_dat_o   <= virt_r ? {ex_pfn, req_offset} : {ex_offset_va, req_offset};
            prot_error <= ex_prot_error;
            miss       <= ex_miss;
            ci         <= ex_ci;
            sel_ptb1   <= ex_space;
        end
    end

    a_answer_pulse: assert property (@(posedge bclk) disable iff (reset)
        (wb_ack || wb_err) |=> !(wb_ack || wb_err));

endmodule

/* hw/mmu_top.sv */
`timescale 1ns/1ps

module mmu_top (
    input  logic                           bclk,
    input  logic                           reset,
    input  logic                           wb_cyc,
    input  logic                           wb_stb,
    input  logic                           wb_we,
    input  logic [31:0]                    wb_adr,
    input  logic [31:0]                    wb_dat_i,
    input  mmu_ctrl_pkg::op_t              wb_tga,
    input  logic                           user,
    input  logic                           rmw,
    input  logic [mmu_ctrl_pkg::mcr_w-1:0] mcr_flags,
    output logic [31:0]                    wb_dat_o,
    output logic                           wb_ack,
    output logic                           wb_err,
    output logic                           prot_error,
    output logic                           miss,
    output logic                           ci,
    output logic                           sel_ptb1
);
    import mmu_ctrl_pkg::*;
    import mmu_entry_pkg::*;

    logic                req_valid;
    op_t                 req_op;
    logic [31:12]        req_va;
    logic [11:0]         req_offset;
    logic                req_write;
    logic                req_user;
    logic                req_rmw;
    logic [31:0]         req_data;
    logic                virt;
    logic                adr_space;
    logic [num_sets-1:0] set_mask;
    logic                done;

    logic                ex_valid;
    op_t                 ex_op;
    logic                ex_hit;
    logic                ex_miss;
    logic                ex_prot_error;
    logic                ex_ci;
    logic                ex_space;
    logic [pfn_w-1:0]    ex_pfn;
    logic [31:12]        ex_offset_va;
    logic [31:0]         update_word;
    logic                commit;
    logic [31:0]         update;

    mmu_decode u_decode (
        .bclk       (bclk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_tga     (wb_tga),
        .user       (user),
        .rmw        (rmw),
        .mcr_flags  (mcr_flags),
        .done       (done),
        .req_valid  (req_valid),
        .req_op     (req_op),
        .req_va     (req_va),
        .req_offset (req_offset),
        .req_write  (req_write),
        .req_user   (req_user),
        .req_rmw    (req_rmw),
        .req_data   (req_data),
        .virt       (virt),
        .adr_space  (adr_space),
        .set_mask   (set_mask)
    );

    mmu_match u_match (
        .bclk          (bclk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_op        (req_op),
        .req_va        (req_va),
        .req_write     (req_write),
        .req_user      (req_user),
        .req_rmw       (req_rmw),
        .req_data      (req_data),
        .virt          (virt),
        .adr_space     (adr_space),
        .set_mask      (set_mask),
        .commit        (commit),
        .update        (update),
        .ex_valid      (ex_valid),
        .ex_op         (ex_op),
        .ex_hit        (ex_hit),
        .ex_miss       (ex_miss),
        .ex_prot_error (ex_prot_error),
        .ex_ci         (ex_ci),
        .ex_space      (ex_space),
        .ex_pfn        (ex_pfn),
        .ex_offset_va  (ex_offset_va),
        .update_word   (update_word),
        .entry_we      ()
    );

    mmu_result u_result (
        .bclk          (bclk),
        .reset         (reset),
        .ex_valid      (ex_valid),
        .ex_op         (ex_op),
        .ex_hit        (ex_hit),
        .ex_miss       (ex_miss),
        .ex_prot_error (ex_prot_error),
        .ex_ci         (ex_ci),
        .ex_space      (ex_space),
        .ex_pfn        (ex_pfn),
        .ex_offset_va  (ex_offset_va),
        .req_offset    (req_offset),
        .update_word   (update_word),
        .virt_r        (virt),
        .commit        (commit),
        .update        (update),
        .wb_dat_o      (wb_dat_o),
        .wb_ack        (wb_ack),
        .wb_err        (wb_err),
        .prot_error    (prot_error),
        .miss          (miss),
        .ci            (ci),
        .sel_ptb1      (sel_ptb1),
        .done          (done)
    );

endmodule

/* dv/tb_mmu_props.sv */
`timescale 1ns/1ps

module tb_mmu_props (
    input  logic        bclk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_ack,
    input  logic        wb_err,
    input  logic [31:0] wb_dat_o,
    input  logic        miss,
    input  logic        prot_error,
    input  logic        ci,
    input  logic        sel_ptb1,
    input  logic        exp_err,
    input  logic        exp_miss,
    input  logic        exp_prot,
    input  logic        exp_ci,
    input  logic        exp_sel,
    input  logic [31:0] exp_dat,
    input  logic        chk_page,
    output int          answers,
    output int          fails
);
    logic in_flight;
    logic accept;
    logic answer;

    assign accept = wb_cyc & wb_stb & ~in_flight;   // Strobe taken by an idle slave
    assign answer = wb_ack | wb_err;

    initial fails = 0;

    always_ff @(posedge bclk) begin
        if (reset) begin
            in_flight <= 1'b0;
            answers   <= 0;
        end else begin
            if (accept) begin
                in_flight <= 1'b1;
            end else if (answer) begin
                in_flight <= 1'b0;
            end
            if (answer) begin
                answers <= answers + 1;
            end
        end
    end

    a_idle_after_reset: assert property (@(posedge bclk) $past(reset) |-> !answer)
        else begin
            $display("Error at %0t: wb_ack or wb_err high during or right after reset", $time);
            fails++;
        end

    a_one_answer: assert property (@(posedge bclk) disable iff (reset)
        $past(accept, 3) |-> (wb_ack ^ wb_err))
        else begin
            $display("Error at %0t: not exactly one of wb_ack and wb_err after a strobe", $time);
            fails++;
        end

    a_no_stray: assert property (@(posedge bclk) disable iff (reset)
        answer |-> $past(accept, 3))
        else begin
            $display("Error at %0t: answer without a strobe three cycles earlier", $time);
            fails++;
        end

    a_one_cycle: assert property (@(posedge bclk) disable iff (reset)
        answer |=> !answer)
        else begin
            $display("Error at %0t: answer lasted more than one cycle", $time);
            fails++;
        end

    a_err: assert property (@(posedge bclk) disable iff (reset)
        $past(accept, 3) |-> (wb_err == exp_err))
        else begin
            $display("Fail at %0t: wb_err expected %0b, got %0b",
                     $time, $sampled(exp_err), $sampled(wb_err));
            fails++;
        end

    a_miss: assert property (@(posedge bclk) disable iff (reset)
        $past(accept, 3) |-> (miss == exp_miss))
        else begin
            $display("Fail at %0t: miss expected %0b, got %0b",
                     $time, $sampled(exp_miss), $sampled(miss));
            fails++;
        end

    a_prot: assert property (@(posedge bclk) disable iff (reset)
        $past(accept, 3) |-> (prot_error == exp_prot))
        else begin
            $display("Fail at %0t: prot_error expected %0b, got %0b",
                     $time, $sampled(exp_prot), $sampled(prot_error));
            fails++;
        end

    a_space: assert property (@(posedge bclk) disable iff (reset)
        $past(accept, 3) |-> (sel_ptb1 == exp_sel))
        else begin
            $display("Fail at %0t: sel_ptb1 expected %0b, got %0b",
                     $time, $sampled(exp_sel), $sampled(sel_ptb1));
            fails++;
        end

    // Address and cache-inhibit only mean something once a page is known
    a_addr: assert property (@(posedge bclk) disable iff (reset)
        ($past(accept, 3) && chk_page) |-> (wb_dat_o == exp_dat))
        else begin
            $display("Fail at %0t: wb_dat_o expected %h, got %h",
                     $time, $sampled(exp_dat), $sampled(wb_dat_o));
            fails++;
        end

    a_ci: assert property (@(posedge bclk) disable iff (reset)
        ($past(accept, 3) && chk_page) |-> (ci == exp_ci))
        else begin
            $display("Fail at %0t: ci expected %0b, got %0b",
                     $time, $sampled(exp_ci), $sampled(ci));
            fails++;
        end

endmodule

/* dv/tb_mmu.sv */
`timescale 1ns/1ps

module tb_mmu;
    import mmu_ctrl_pkg::*;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 16;
    localparam int n_phys       = 8;
    localparam int n_load       = 8;    // Even sets only, odd sets stay empty
    localparam int n_miss       = 14;
    localparam int n_prot       = 39;   // Four levels of one load and eight accesses, plus three
    localparam int n_inval      = 12;
    localparam int n_rand       = 20;
    localparam int num_requests = n_phys + 2 * n_load + n_miss + n_prot + n_inval + n_rand;

    logic        bclk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_i;
    op_t         wb_tga;
    logic        user;
    logic        rmw;
    logic [2:0]  mcr_flags;
    logic [31:0] wb_dat_o;
    logic        wb_ack;
    logic        wb_err;
    logic        prot_error;
    logic        miss;
    logic        ci;
    logic        sel_ptb1;

    // Expected answer of the request in flight
    logic        exp_err;
    logic        exp_miss;
    logic        exp_prot;
    logic        exp_ci;
    logic        exp_sel;
    logic [31:0] exp_dat;
    logic        chk_page;
    int          answers;
    int          fails;

    // Reference model of the sets
    logic        m_valid [16];
    logic        m_space [16];
    logic [11:0] m_tag   [16];
    prot_t       m_prot  [16];
    logic        m_we    [16];
    logic        m_ci    [16];
    logic [19:0] m_pfn   [16];

    logic [2:0]  mode;
    logic [11:0] tags [n_load];
    logic [11:0] tag;
    logic [3:0]  set4;
    int          hs_errors;
    int          answers_at_start;
    int          fails_at_start;

    mmu_top dut0 (.*);

    tb_mmu_props props0 (.*);

    initial begin
        bclk = 1'b0;
        forever #(clk_period / 2) bclk = ~bclk;
    end

    initial begin
        #((num_requests * 10 + reset_cycles) * clk_period);
        $display("Watchdog expired at %0t before all requests were answered", $time);
        $display("Test failed");
        $finish;
    end

    function automatic logic random_bit();
        return 1'($urandom);
    endfunction

    // Bits 19:16 take no part in matching
    function automatic logic [31:0] make_va(input logic [11:0] vtag, input logic [3:0] set_idx,
                                            input logic [11:0] off);
        return {vtag, 4'($urandom), set_idx, off};
    endfunction

    function automatic logic [31:0] load_word(input logic [19:0] pfn, input prot_t prot,
                                              input logic we, input logic cinh, input logic sp);
        return {pfn, 4'h0, prot, we, cinh, 3'b000, sp};
    endfunction

    task automatic issue_request(input op_t op, input logic [31:0] va, input logic [31:0] dat,
                                 input logic we, input logic us, input logic rw);
        int   set_idx;
        int   waited;
        logic virt;
        logic space;
        logic match;
        logic perr;
        set_idx = int'(va[15:12]);
        virt    = us ? mode[mcr_virt_user] : mode[mcr_virt_super];
        space   = (op == op_translate) ? (mode[mcr_dual_space] & us) : dat[0];
        match   = m_valid[set_idx] && (m_tag[set_idx] == va[31:20])
                  && (m_space[set_idx] == space);
        perr    = 1'b0;
        if (op == op_translate && virt && match) begin
            case (m_prot[set_idx])
                prot_none_user:  perr = us || we || rw;
                prot_super_only: perr = us;
                prot_user_read:  perr = us && (we || rw);
                default:         perr = 1'b0;
            endcase
        end
        @(posedge bclk);
        wb_cyc    <= 1'b1;
        wb_stb    <= 1'b1;
        wb_tga    <= op;
        wb_adr    <= va;
        wb_dat_i  <= dat;
        wb_we     <= we;
        user      <= us;
        rmw       <= rw;
        mcr_flags <= mode;
        exp_err   <= (op == op_translate) && virt && (!match || perr || (we && !m_we[set_idx]));
        exp_miss  <= (op == op_translate) && virt && !match;
        exp_prot  <= perr;
        exp_sel   <= space;
        exp_dat   <= virt ? {m_pfn[set_idx], va[11:0]} : va;
        exp_ci    <= virt && m_ci[set_idx];
        chk_page  <= (op == op_translate) && (!virt || match);
        waited = 0;
        do begin
            @(posedge bclk);
            waited++;
        end while (!(wb_ack || wb_err) && waited < 8);
        if (!(wb_ack || wb_err)) begin
            $display("Error at %0t: request got no answer within 8 cycles", $time);
            hs_errors++;
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        if (op == op_load) begin
            m_valid[set_idx] = 1'b1;
            m_space[set_idx] = dat[0];
            m_tag[set_idx]   = va[31:20];
            m_prot[set_idx]  = prot_t'(dat[7:6]);
            m_we[set_idx]    = dat[5];
            m_ci[set_idx]    = dat[4];
            m_pfn[set_idx]   = dat[31:12];
        end else if (op == op_inval && match) begin
            m_valid[set_idx] = 1'b0;
        end
    endtask

    task automatic begin_test();
        answers_at_start = answers;
        fails_at_start   = fails + hs_errors;
    endtask

    task automatic report_test(input string name);
        @(posedge bclk);                            // Checks of the last answer have run
        $display("%s: %0d answers, %0d failures", name, answers - answers_at_start,
                 fails + hs_errors - fails_at_start);
    endtask

    initial begin
        void'($urandom(79));
        reset     = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_i  = '0;
        wb_tga    = op_translate;
        user      = 1'b0;
        rmw       = 1'b0;
        mcr_flags = '0;
        exp_err   = 1'b0;
        exp_miss  = 1'b0;
        exp_prot  = 1'b0;
        exp_ci    = 1'b0;
        exp_sel   = 1'b0;
        exp_dat   = '0;
        chk_page  = 1'b0;
        mode      = '0;
        hs_errors = 0;
        for (int s = 0; s < 16; s++) begin
            m_valid[s] = 1'b0;
            m_space[s] = 1'b0;
            m_tag[s]   = '0;
            m_prot[s]  = prot_none_user;
            m_we[s]    = 1'b0;
            m_ci[s]    = 1'b0;
            m_pfn[s]   = '0;
        end
        repeat (reset_cycles) @(posedge bclk);
        reset <= 1'b0;

        begin_test();
        mode = 3'b000;
        for (int i = 0; i < n_phys; i++) begin
            issue_request(op_translate, $urandom, $urandom, random_bit(), random_bit(),
                          random_bit());
        end
        report_test("physical");

        begin_test();
        mode = 3'b011;
        for (int i = 0; i < n_load; i++) begin
            tags[i] = 12'($urandom);
            issue_request(op_load, make_va(tags[i], 4'(2 * i), 12'h0),
                          load_word(20'($urandom), prot_t'(2'($urandom)), random_bit(),
                                    random_bit(), 1'b0), 1'b0, 1'b0, 1'b0);
        end
        for (int i = 0; i < n_load; i++) begin
            issue_request(op_translate, make_va(tags[i], 4'(2 * i), 12'($urandom)), '0,
                          1'b0, 1'b0, 1'b0);
        end
        report_test("load and hit");

        begin_test();
        for (int i = 0; i < 4; i++) begin
            issue_request(op_translate, make_va(tags[i] ^ 12'h801, 4'(2 * i), 12'($urandom)),
                          '0, 1'b0, 1'b0, 1'b0);
            issue_request(op_translate, make_va(12'($urandom), 4'(2 * i + 1), 12'($urandom)),
                          '0, 1'b0, 1'b0, 1'b0);
        end
        mode = 3'b111;                              // User runs in space 1
        for (int i = 0; i < 4; i++) begin
            issue_request(op_translate, make_va(tags[i], 4'(2 * i), 12'($urandom)), '0,
                          1'b0, 1'b1, 1'b0);
        end
        issue_request(op_translate, make_va(tags[0], 4'd0, 12'h0), '0, 1'b0, 1'b0, 1'b0);
        mode = 3'b011;
        issue_request(op_translate, make_va(tags[1], 4'd2, 12'h0), '0, 1'b0, 1'b1, 1'b0);
        report_test("miss");

        begin_test();
        for (int lvl = 0; lvl < 4; lvl++) begin
            tag = 12'($urandom);
            issue_request(op_load, make_va(tag, 4'd1, 12'h0),
                          load_word(20'($urandom), prot_t'(2'(lvl)), 1'b1, random_bit(), 1'b0),
                          1'b0, 1'b0, 1'b0);
            for (int acc = 0; acc < 8; acc++) begin
                issue_request(op_translate, make_va(tag, 4'd1, 12'($urandom)), '0,
                              acc[1], acc[2], acc[0]);
            end
        end
        // Entry without write permission refuses any write
        tag = 12'($urandom);
        issue_request(op_load, make_va(tag, 4'd1, 12'h0),
                      load_word(20'($urandom), prot_all, 1'b0, 1'b0, 1'b0), 1'b0, 1'b0, 1'b0);
        issue_request(op_translate, make_va(tag, 4'd1, 12'h0), '0, 1'b1, 1'b0, 1'b0);
        issue_request(op_translate, make_va(tag, 4'd1, 12'h0), '0, 1'b0, 1'b1, 1'b1);
        report_test("protection");

        begin_test();
        for (int k = 4; k < 6; k++) begin
            issue_request(op_inval, make_va(tags[k] ^ 12'h010, 4'(2 * k), 12'h0), '0,
                          1'b0, 1'b0, 1'b0);
            issue_request(op_translate, make_va(tags[k], 4'(2 * k), 12'h0), '0, 1'b0, 1'b0, 1'b0);
            issue_request(op_inval, make_va(tags[k], 4'(2 * k), 12'h0), 32'h1, 1'b0, 1'b0, 1'b0);
            issue_request(op_translate, make_va(tags[k], 4'(2 * k), 12'h0), '0, 1'b0, 1'b0, 1'b0);
            issue_request(op_inval, make_va(tags[k], 4'(2 * k), 12'h0), '0, 1'b0, 1'b0, 1'b0);
            issue_request(op_translate, make_va(tags[k], 4'(2 * k), 12'h0), '0, 1'b0, 1'b0, 1'b0);
        end
        report_test("invalidate");

        begin_test();
        for (int i = 0; i < n_rand; i++) begin
            mode = 3'($urandom);
            set4 = 4'($urandom);
            tag  = random_bit() ? m_tag[set4] : 12'($urandom);  // Half aim at a known tag
            issue_request(op_t'(2'($urandom_range(2, 0))), make_va(tag, set4, 12'($urandom)),
                          $urandom, random_bit(), random_bit(), random_bit());
        end
        report_test("random mix");

        $display("Summary: %0d of %0d requests answered, %0d failures", answers, num_requests,
                 fails + hs_errors);
        if (fails + hs_errors == 0 && answers == num_requests) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb.f */
hw/mmu_ctrl_pkg.sv
hw/mmu_entry_pkg.sv
hw/mmu_decode.sv
hw/mmu_match.sv
hw/mmu_result.sv
hw/mmu_top.sv
dv/tb_mmu_props.sv
dv/tb_mmu.sv

/* Makefile */
.PHONY: all build run lint clean

all: build run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_mmu -f tb.f -o Vtb_mmu

run: build
	./obj_dir/Vtb_mmu | tee sim.log
	grep -q "^Test passed$$" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module tb_mmu -f tb.f

clean:
	rm -rf obj_dir sim.log
